// File: hdl/noc_pkg.sv
//~~~~~~~~~~~~~~~~~~~~
// packets are always eight 4-bit flits and the head flit carries the XY target
//~~~~~~~~~~~~~~~~~~~~
package noc_pkg;

	localparam int FLIT_W = 4;
	localparam int PACKET_W = 32;
	localparam int FLITS_PER_PACKET = 8;
	localparam int NUM_PORTS = 5;
	localparam int COORD_W = 2;

	// bit order of every request and grant vector
	localparam int PORT_LOCAL = 0;
	localparam int PORT_NORTH = 1;
	localparam int PORT_SOUTH = 2;
	localparam int PORT_EAST = 3;
	localparam int PORT_WEST = 4;

	// one packet word seen either as routing fields or as its flits
	// flit 7 is the head and goes out first
	typedef union packed {
		struct packed {
			logic [COORD_W-1:0] dest_x;
			logic [COORD_W-1:0] dest_y;
			logic [PACKET_W-2*COORD_W-1:0] payload;
		} fields;
		logic [FLITS_PER_PACKET-1:0][FLIT_W-1:0] flits;
	} noc_packet_u;

endpackage

// File: hdl/route_req_if.sv
//~~~~~~~~~~~~~~~~~~~~
// grant is formed outside from the per-output grants bits
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

interface route_req_if;
	import noc_pkg::*;

	logic [NUM_PORTS-1:0] request;	// one-hot wanted output
	logic [FLIT_W-1:0] flit;	// flit at the input FIFO head
	logic tail;			// that flit closes the packet
	logic [NUM_PORTS-1:0] grants;	// one bit from each output arbiter
	logic grant;			// some output takes the flit this cycle

	modport requester (
		output request,
		output flit,
		output tail,
		input grant
	);

	modport arbiter (
		input request,
		input flit,
		input tail,
		output grants
	);

endinterface

// File: hdl/flit_fifo.sv
//~~~~~~~~~~~~~~~~~~~~
// show-ahead FIFO with DEPTH of at least 2; writes while full are dropped
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module flit_fifo #(
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic reset,
	input logic [noc_pkg::FLIT_W-1:0] data,
	input logic write_en,
	output logic full,
	input logic read,
	output logic [noc_pkg::FLIT_W-1:0] q,
	output logic empty
);
	import noc_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [FLIT_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic wr_ok;
	logic rd_ok;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign wr_ok = write_en && !full;
	assign rd_ok = read && !empty;
	assign q = mem[rd_ptr];	// head always visible

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_ok)
			mem[wr_ptr] <= data;
	end

endmodule

// File: hdl/local_packet_fifo.sv
//~~~~~~~~~~~~~~~~~~~~
// full counts the word being serialized; flit 7 of each word leaves first
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module local_packet_fifo #(
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic [noc_pkg::PACKET_W-1:0] data,
	input logic write_en,
	output logic full,
	input logic read,
	output logic [noc_pkg::FLIT_W-1:0] q,
	output logic empty,
	output logic last
);
	import noc_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam int IDX_W = $clog2(FLITS_PER_PACKET);

	noc_packet_u mem [DEPTH];
	noc_packet_u head;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [IDX_W-1:0] flit_idx;	// counts down from the head flit
	logic wr_ok;
	logic retire;

	assign full = (count == CNT_W'(DEPTH));
	assign empty = (count == '0);
	assign wr_ok = write_en && !full;
	assign head = mem[rd_ptr];
	assign q = head.flits[flit_idx];
	assign last = (flit_idx == '0);
	assign retire = read && !empty && last;	// word leaves with its last flit

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			flit_idx <= IDX_W'(FLITS_PER_PACKET - 1);
		end
		else
		begin
			if (wr_ok)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (retire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (read && !empty)
				flit_idx <= flit_idx - 1'b1;	// wraps back to 7 on retire
			count <= count + CNT_W'(wr_ok) - CNT_W'(retire);
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_ok)
			mem[wr_ptr] <= data;
	end

endmodule

// File: hdl/input_port.sv
//~~~~~~~~~~~~~~~~~~~~
// XY routing for one input; assumes every packet is exactly eight flits
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module input_port #(
	parameter int X_COORD = 0,
	parameter int Y_COORD = 0
) (
	input logic clk,
	input logic reset,
	input logic [noc_pkg::FLIT_W-1:0] q,
	input logic empty,
	input logic last,
	output logic read,
	route_req_if.requester req
);
	import noc_pkg::*;

	localparam int CNT_W = $clog2(FLITS_PER_PACKET);

	noc_packet_u head_word;
	logic in_packet;	// head has moved and the route is held
	logic [CNT_W-1:0] count;
	logic [NUM_PORTS-1:0] route_comb;
	logic [NUM_PORTS-1:0] route_reg;
	logic [NUM_PORTS-1:0] route;
	logic move;

	// place the head flit where the packet word keeps it to decode the target
	always_comb
	begin
		head_word = '0;
		head_word.flits[FLITS_PER_PACKET-1] = q;
		route_comb = '0;
		if (int'(head_word.fields.dest_x) > X_COORD)
			route_comb[PORT_EAST] = 1'b1;
		else if (int'(head_word.fields.dest_x) < X_COORD)
			route_comb[PORT_WEST] = 1'b1;
		else if (int'(head_word.fields.dest_y) > Y_COORD)
			route_comb[PORT_NORTH] = 1'b1;
		else if (int'(head_word.fields.dest_y) < Y_COORD)
			route_comb[PORT_SOUTH] = 1'b1;
		else
			route_comb[PORT_LOCAL] = 1'b1;
	end

	assign route = in_packet ? route_reg : route_comb;
	assign move = req.grant && !empty;
	assign read = move;

	assign req.request = empty ? '0 : route;
	assign req.flit = q;
	// the local FIFO marks its own last flit and neighbor links tie last low
	assign req.tail = last || (count == CNT_W'(FLITS_PER_PACKET - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			in_packet <= 1'b0;
			count <= '0;
		end
		else if (move)
		begin
			in_packet <= !req.tail;
			count <= req.tail ? '0 : count + 1'b1;
		end
	end

	// route captured when the head flit moves
	always_ff @(posedge clk)
	begin
		if (move && !in_packet)
			route_reg <= route_comb;
	end

endmodule

// File: hdl/output_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~
// grant is combinational and held for a whole packet through full stalls
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module output_arbiter #(
	parameter int PORT_ID = 0
) (
	input logic clk,
	input logic reset,
	route_req_if.arbiter reqs [noc_pkg::NUM_PORTS],
	input logic neighbor_full,
	output logic [noc_pkg::FLIT_W-1:0] out,
	output logic write_req
);
	import noc_pkg::*;

	localparam int SEL_W = $clog2(NUM_PORTS);

	logic [NUM_PORTS-1:0] req_vec;
	logic [NUM_PORTS-1:0] tails;
	logic [FLIT_W-1:0] flits [NUM_PORTS];
	logic [NUM_PORTS-1:0] grant_vec;
	logic locked;
	logic [SEL_W-1:0] owner;
	logic [SEL_W-1:0] ptr;	// highest priority input when unlocked
	logic [SEL_W-1:0] pick;
	logic [SEL_W-1:0] winner;
	logic found;
	logic sel_valid;

	for (genvar i = 0; i < NUM_PORTS; i++)
	begin : g_link
		assign req_vec[i] = reqs[i].request[PORT_ID] && !neighbor_full;
		assign tails[i] = reqs[i].tail;
		assign flits[i] = reqs[i].flit;
		assign reqs[i].grants[PORT_ID] = grant_vec[i];
	end

	// first requester at or after the pointer
	always_comb
	begin
		logic [SEL_W-1:0] idx;
		pick = ptr;
		found = 1'b0;
		for (int k = 0; k < NUM_PORTS; k++)
		begin
			idx = SEL_W'((int'(ptr) + k) % NUM_PORTS);
			if (!found && req_vec[idx])
			begin
				pick = idx;
				found = 1'b1;
			end
		end
	end

	assign winner = locked ? owner : pick;
	assign sel_valid = locked ? req_vec[owner] : found;
	assign grant_vec = sel_valid ? (NUM_PORTS'(1) << winner) : '0;
	assign out = flits[winner];	// the crossbar column for this output
	assign write_req = sel_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			locked <= 1'b0;
			owner <= SEL_W'(PORT_LOCAL);
			ptr <= SEL_W'(PORT_LOCAL);
		end
		else if (sel_valid)
		begin
			if (tails[winner])
			begin
				locked <= 1'b0;
				ptr <= (winner == SEL_W'(NUM_PORTS - 1)) ? '0 : winner + 1'b1;
			end
			else
			begin
				locked <= 1'b1;
				owner <= winner;
			end
		end
	end

endmodule

// File: hdl/noc_router.sv
//~~~~~~~~~~~~~~~~~~~~
// single clock router; links use a write strobe and a full level
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module noc_router #(
	parameter int X_COORD = 1,
	parameter int Y_COORD = 1,
	parameter int FIFO_DEPTH = 16,
	parameter int LOCAL_DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic [noc_pkg::PACKET_W-1:0] local_in,
	input logic local_write_en,
	output logic local_full,
	input logic [noc_pkg::FLIT_W-1:0] north_in,
	input logic north_write_en,
	output logic north_full,
	input logic [noc_pkg::FLIT_W-1:0] south_in,
	input logic south_write_en,
	output logic south_full,
	input logic [noc_pkg::FLIT_W-1:0] east_in,
	input logic east_write_en,
	output logic east_full,
	input logic [noc_pkg::FLIT_W-1:0] west_in,
	input logic west_write_en,
	output logic west_full,
	output logic [noc_pkg::FLIT_W-1:0] local_out,
	output logic local_write_req,
	output logic [noc_pkg::FLIT_W-1:0] north_out,
	output logic north_write_req,
	output logic [noc_pkg::FLIT_W-1:0] south_out,
	output logic south_write_req,
	output logic [noc_pkg::FLIT_W-1:0] east_out,
	output logic east_write_req,
	output logic [noc_pkg::FLIT_W-1:0] west_out,
	output logic west_write_req,
	input logic local_neuron_full,
	input logic north_neighbor_full,
	input logic south_neighbor_full,
	input logic east_neighbor_full,
	input logic west_neighbor_full
);
	import noc_pkg::*;

	logic [FLIT_W-1:0] link_in [PORT_NORTH:PORT_WEST];
	logic link_write_en [PORT_NORTH:PORT_WEST];
	logic link_full [PORT_NORTH:PORT_WEST];
	logic [FLIT_W-1:0] head_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] head_empty;
	logic [NUM_PORTS-1:0] head_read;
	logic [NUM_PORTS-1:0] head_last;
	logic [FLIT_W-1:0] out_flit [NUM_PORTS];
	logic [NUM_PORTS-1:0] out_write_req;
	logic [NUM_PORTS-1:0] dest_full;

	route_req_if req_if [NUM_PORTS] ();

	assign link_in = '{north_in, south_in, east_in, west_in};
	assign link_write_en = '{north_write_en, south_write_en, east_write_en, west_write_en};
	assign north_full = link_full[PORT_NORTH];
	assign south_full = link_full[PORT_SOUTH];
	assign east_full = link_full[PORT_EAST];
	assign west_full = link_full[PORT_WEST];

	// west east south north local
	assign dest_full = {west_neighbor_full, east_neighbor_full, south_neighbor_full,
		north_neighbor_full, local_neuron_full};

	assign local_out = out_flit[PORT_LOCAL];
	assign north_out = out_flit[PORT_NORTH];
	assign south_out = out_flit[PORT_SOUTH];
	assign east_out = out_flit[PORT_EAST];
	assign west_out = out_flit[PORT_WEST];
	assign {west_write_req, east_write_req, south_write_req, north_write_req,
		local_write_req} = out_write_req;

	local_packet_fifo #(.DEPTH(LOCAL_DEPTH)) i_local_fifo (
		.clk(clk),
		.reset(reset),
		.data(local_in),
		.write_en(local_write_en),
		.full(local_full),
		.read(head_read[PORT_LOCAL]),
		.q(head_flit[PORT_LOCAL]),
		.empty(head_empty[PORT_LOCAL]),
		.last(head_last[PORT_LOCAL])
	);

	for (genvar i = PORT_NORTH; i <= PORT_WEST; i++)
	begin : g_link_fifo
		flit_fifo #(.DEPTH(FIFO_DEPTH)) i_flit_fifo (
			.clk(clk),
			.reset(reset),
			.data(link_in[i]),
			.write_en(link_write_en[i]),
			.full(link_full[i]),
			.read(head_read[i]),
			.q(head_flit[i]),
			.empty(head_empty[i])
		);
		assign head_last[i] = 1'b0;	// counted in input_port
	end

	for (genvar i = 0; i < NUM_PORTS; i++)
	begin : g_port
		input_port #(.X_COORD(X_COORD), .Y_COORD(Y_COORD)) i_input_port (
			.clk(clk),
			.reset(reset),
			.q(head_flit[i]),
			.empty(head_empty[i]),
			.last(head_last[i]),
			.read(head_read[i]),
			.req(req_if[i])
		);

		// an input moves when any output grants it
		assign req_if[i].grant = |req_if[i].grants;

		output_arbiter #(.PORT_ID(i)) i_output_arbiter (
			.clk(clk),
			.reset(reset),
			.reqs(req_if),
			.neighbor_full(dest_full[i]),
			.out(out_flit[i]),
			.write_req(out_write_req[i])
		);
	end

endmodule

// File: tests/noc_router_assertions.sv
//~~~~~~~~~~~~~~~~~~~~
// bound into every output_arbiter; quiet while reset is high
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module noc_router_assertions (
	input logic clk,
	input logic reset,
	input logic neighbor_full,
	input logic write_req,
	input logic [noc_pkg::NUM_PORTS-1:0] grant_vec,
	input logic [noc_pkg::NUM_PORTS-1:0] tails,
	input logic locked,
	input logic sel_valid,
	input logic [$clog2(noc_pkg::NUM_PORTS)-1:0] owner
);

	no_write_into_full: assert property (@(posedge clk) disable iff (reset)
		neighbor_full |-> !write_req)
		else $error("write_req high while the neighbor is full");

	grant_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0(grant_vec))
		else $error("more than one input granted");

	// a locked packet keeps its owner until its tail flit moves
	lock_until_tail: assert property (@(posedge clk) disable iff (reset)
		locked && !(sel_valid && tails[owner]) |=> locked && $stable(owner))
		else $error("lock dropped before the tail flit");

endmodule

bind output_arbiter noc_router_assertions i_arbiter_checks (
	.clk(clk),
	.reset(reset),
	.neighbor_full(neighbor_full),
	.write_req(write_req),
	.grant_vec(grant_vec),
	.tails(tails),
	.locked(locked),
	.sel_valid(sel_valid),
	.owner(owner)
);

// File: tests/noc_router_tb.sv
//~~~~~~~~~~~~~~~~~~~~
// router placed at (1,1); run from the project root so the golden file is found
//~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns

module noc_router_tb;
	import noc_pkg::*;

	localparam int ROUTER_X = 1;
	localparam int ROUTER_Y = 1;
	localparam int LOCAL_DEPTH = 4;
	localparam int MAX_PKTS = 32;

	logic clk;
	logic reset;
	logic [PACKET_W-1:0] local_in;
	logic local_write_en;
	logic [FLIT_W-1:0] link_data [PORT_NORTH:PORT_WEST];
	logic link_we [PORT_NORTH:PORT_WEST];
	logic [NUM_PORTS-1:0] full_vec;
	logic [NUM_PORTS-1:0][FLIT_W-1:0] out_flit;
	logic [NUM_PORTS-1:0] write_req_vec;
	logic [NUM_PORTS-1:0] neighbor_full;

	logic [31:0] golden [5*MAX_PKTS];
	int pkt_test [MAX_PKTS];
	int pkt_src [MAX_PKTS];
	logic [PACKET_W-1:0] pkt_word [MAX_PKTS];
	int pkt_hold [MAX_PKTS];
	int n_pkts;
	int pending [$];	// packet indices not yet delivered
	int deliveries [$];	// delivery order of the current test
	int errors;
	integer seed;
	logic loaded;

	noc_router #(.X_COORD(ROUTER_X), .Y_COORD(ROUTER_Y), .LOCAL_DEPTH(LOCAL_DEPTH)) i_noc_router (
		.clk(clk),
		.reset(reset),
		.local_in(local_in),
		.local_write_en(local_write_en),
		.local_full(full_vec[PORT_LOCAL]),
		.north_in(link_data[PORT_NORTH]),
		.north_write_en(link_we[PORT_NORTH]),
		.north_full(full_vec[PORT_NORTH]),
		.south_in(link_data[PORT_SOUTH]),
		.south_write_en(link_we[PORT_SOUTH]),
		.south_full(full_vec[PORT_SOUTH]),
		.east_in(link_data[PORT_EAST]),
		.east_write_en(link_we[PORT_EAST]),
		.east_full(full_vec[PORT_EAST]),
		.west_in(link_data[PORT_WEST]),
		.west_write_en(link_we[PORT_WEST]),
		.west_full(full_vec[PORT_WEST]),
		.local_out(out_flit[PORT_LOCAL]),
		.local_write_req(write_req_vec[PORT_LOCAL]),
		.north_out(out_flit[PORT_NORTH]),
		.north_write_req(write_req_vec[PORT_NORTH]),
		.south_out(out_flit[PORT_SOUTH]),
		.south_write_req(write_req_vec[PORT_SOUTH]),
		.east_out(out_flit[PORT_EAST]),
		.east_write_req(write_req_vec[PORT_EAST]),
		.west_out(out_flit[PORT_WEST]),
		.west_write_req(write_req_vec[PORT_WEST]),
		.local_neuron_full(neighbor_full[PORT_LOCAL]),
		.north_neighbor_full(neighbor_full[PORT_NORTH]),
		.south_neighbor_full(neighbor_full[PORT_SOUTH]),
		.east_neighbor_full(neighbor_full[PORT_EAST]),
		.west_neighbor_full(neighbor_full[PORT_WEST])
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// XY rule: x first, then y, north is the larger y
	function automatic int route_of(input logic [PACKET_W-1:0] word);
		noc_packet_u p;
		p = word;
		if (int'(p.fields.dest_x) > ROUTER_X)
			return PORT_EAST;
		if (int'(p.fields.dest_x) < ROUTER_X)
			return PORT_WEST;
		if (int'(p.fields.dest_y) > ROUTER_Y)
			return PORT_NORTH;
		if (int'(p.fields.dest_y) < ROUTER_Y)
			return PORT_SOUTH;
		return PORT_LOCAL;
	endfunction

	task automatic write_word(input logic [PACKET_W-1:0] word);
		@(posedge clk);
		#1;
		while (full_vec[PORT_LOCAL])
		begin
			@(posedge clk);
			#1;
		end
		local_in = word;
		local_write_en = 1'b1;
		@(posedge clk);
		#1;
		local_write_en = 1'b0;
	endtask

	task automatic write_flits(input int src, input logic [PACKET_W-1:0] word);
		noc_packet_u p;
		p = word;
		for (int f = FLITS_PER_PACKET - 1; f >= 0; f--)
		begin
			@(posedge clk);
			#1;
			while (full_vec[src])
			begin
				link_we[src] = 1'b0;	// wait for room upstream
				@(posedge clk);
				#1;
			end
			link_data[src] = p.flits[f];
			link_we[src] = 1'b1;
		end
		@(posedge clk);
		#1;
		link_we[src] = 1'b0;
	endtask

	task automatic inject_source(input int src, input int lo, input int hi);
		int gap;
		for (int i = lo; i < hi; i++)
		begin
			if (pkt_src[i] == src)
			begin
				gap = $unsigned($random(seed)) % 4;
				repeat (gap) @(posedge clk);
				if (src == PORT_LOCAL)
					write_word(pkt_word[i]);
				else
					write_flits(src, pkt_word[i]);
			end
		end
	endtask

	task automatic hold_outputs(input logic [NUM_PORTS-1:0] mask, input int len,
		input int local_cnt);
		repeat (len)
		begin
			@(negedge clk);
			if ((write_req_vec & mask) != '0)
			begin
				$display("ERROR %0t ns: write_req %b while neighbor full %b", $time,
					write_req_vec, mask);
				errors++;
			end
		end
		if (mask[PORT_LOCAL] && local_cnt >= LOCAL_DEPTH && !full_vec[PORT_LOCAL])
		begin
			$display("ERROR %0t ns: local_full low with %0d words queued", $time, local_cnt);
			errors++;
		end
		@(posedge clk);
		#1;
		neighbor_full = '0;
	endtask

	task automatic retire_word(input int port, input logic [PACKET_W-1:0] word);
		int hit;
		hit = -1;
		foreach (pending[k])
		begin
			if (hit < 0 && pkt_word[pending[k]] == word && route_of(word) == port)
				hit = k;
		end
		if (hit < 0)
		begin
			$display("ERROR %0t ns: unexpected word %h on output %0d", $time, word, port);
			errors++;
		end
		else
		begin
			deliveries.push_back(pending[hit]);
			pending.delete(hit);
		end
	endtask

	task automatic watch_output(input int port);
		noc_packet_u word;
		int n;
		n = 0;
		word = '0;
		forever
		begin
			@(negedge clk);
			if (!reset && write_req_vec[port])
			begin
				word.flits[FLITS_PER_PACKET-1-n] = out_flit[port];	// head arrives first
				n++;
				if (n == FLITS_PER_PACKET)
				begin
					n = 0;
					retire_word(port, word);
				end
			end
		end
	endtask

	for (genvar g = 0; g < NUM_PORTS; g++)
	begin : g_watch
		initial watch_output(g);
	end

	// on a held output the queued sources must take turns
	task automatic check_rotation(input logic [NUM_PORTS-1:0] mask, input int lo, input int hi);
		int left [NUM_PORTS];
		int prev;
		int src;
		int others;
		for (int port = 0; port < NUM_PORTS; port++)
		begin
			if (mask[port])
			begin
				for (int s = 0; s < NUM_PORTS; s++)
					left[s] = 0;
				for (int i = lo; i < hi; i++)
					if (route_of(pkt_word[i]) == port)
						left[pkt_src[i]]++;
				prev = -1;
				foreach (deliveries[k])
				begin
					if (route_of(pkt_word[deliveries[k]]) == port)
					begin
						src = pkt_src[deliveries[k]];
						others = 0;
						for (int s = 0; s < NUM_PORTS; s++)
							if (s != src)
								others += left[s];
						if (src == prev && others > 0)
						begin
							$display("ERROR %0t ns: source %0d served twice in a row on output %0d",
								$time, src, port);
							errors++;
						end
						left[src]--;
						prev = src;
					end
				end
			end
		end
	endtask

	task automatic run_test(input int lo, input int hi);
		logic [NUM_PORTS-1:0] hold_mask;
		int hold_len;
		int local_cnt;
		hold_mask = '0;
		hold_len = 0;
		local_cnt = 0;
		deliveries.delete();
		for (int i = lo; i < hi; i++)
		begin
			pending.push_back(i);
			if (pkt_hold[i] > 0)
				hold_mask[route_of(pkt_word[i])] = 1'b1;
			if (pkt_hold[i] > hold_len)
				hold_len = pkt_hold[i];
			if (pkt_src[i] == PORT_LOCAL)
				local_cnt++;
		end
		$display("test %0d: %0d packets", pkt_test[lo], hi - lo);
		@(posedge clk);
		#1;
		neighbor_full = hold_mask;
		fork
			hold_outputs(hold_mask, hold_len, local_cnt);
			inject_source(PORT_LOCAL, lo, hi);
			inject_source(PORT_NORTH, lo, hi);
			inject_source(PORT_SOUTH, lo, hi);
			inject_source(PORT_EAST, lo, hi);
			inject_source(PORT_WEST, lo, hi);
		join
		while (pending.size() != 0)
			@(posedge clk);
		check_rotation(hold_mask, lo, hi);
	endtask

	initial
	begin
		int first;
		int last;
		reset = 1'b1;
		local_in = '0;
		local_write_en = 1'b0;
		for (int i = PORT_NORTH; i <= PORT_WEST; i++)
		begin
			link_data[i] = '0;
			link_we[i] = 1'b0;
		end
		neighbor_full = '0;
		errors = 0;
		seed = 32'hf343_9f2f;
		loaded = 1'b0;
		for (int i = 0; i < 5 * MAX_PKTS; i++)
			golden[i] = '1;	// marks rows the file leaves empty
		$readmemh("tests/noc_router_golden.txt", golden);
		n_pkts = 0;
		while (n_pkts < MAX_PKTS && golden[5*n_pkts] != '1)
		begin
			pkt_test[n_pkts] = int'(golden[5*n_pkts]);
			pkt_src[n_pkts] = int'(golden[5*n_pkts+1]);
			pkt_word[n_pkts] = golden[5*n_pkts+2];
			pkt_hold[n_pkts] = int'(golden[5*n_pkts+4]);
			if (route_of(pkt_word[n_pkts]) != int'(golden[5*n_pkts+3]))
			begin
				$display("ERROR %0t ns: golden row %0d names port %0d, routing gives %0d", $time,
					n_pkts, golden[5*n_pkts+3], route_of(pkt_word[n_pkts]));
				errors++;
			end
			n_pkts++;
		end
		if (n_pkts == 0)
		begin
			$display("the golden file could not be read or holds no packets");
			errors++;
		end
		loaded = 1'b1;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		if (write_req_vec != '0 || full_vec != '0)
		begin
			$display("ERROR %0t ns: after reset write_req %b full %b", $time,
				write_req_vec, full_vec);
			errors++;
		end

		first = 0;
		while (first < n_pkts)
		begin
			last = first;
			while (last < n_pkts && pkt_test[last] == pkt_test[first])
				last++;
			run_test(first, last);
			first = last;
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// budget of 40 cycles per flit
	initial
	begin
		wait (loaded);
		repeat (n_pkts * FLITS_PER_PACKET * 40) @(posedge clk);
		$display("timeout: %0d packets still undelivered", pending.size());
		$display("Something failed");
		$finish;
	end

endmodule

// File: noc_router.f
hdl/noc_pkg.sv
hdl/route_req_if.sv
hdl/flit_fifo.sv
hdl/local_packet_fifo.sv
hdl/input_port.sv
hdl/output_arbiter.sv
hdl/noc_router.sv
tests/noc_router_assertions.sv
tests/noc_router_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the router testbench with Verilator, run it, and look for the pass line
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module noc_router_tb \
	-f noc_router.f -o noc_router_sim > build.log 2>&1 ||
	{ echo "build failed, see build.log"; exit 1; }
./obj_dir/noc_router_sim > sim.log 2>&1
cat sim.log
grep -q "^Everything OK$" sim.log && echo "PASS" && exit 0 ||
	{ echo "FAIL"; exit 1; }

// File: tests/noc_router_golden.txt
// columns: test, source port, packet word, expected output port, neighbor_full hold cycles
// ports: 0 local, 1 north, 2 south, 3 east, 4 west; all values hex; router sits at (1,1)
02 0 8a3c51e7 3 00
02 1 2b7e0914 4 00
02 2 6d41f3a2 1 00
02 3 4e9027c5 2 00
02 4 5f18b36d 0 00
03 1 c3a5f01e 3 00
03 4 b6d2e847 3 00
03 0 7149ac3d 1 00
03 2 6f0b52d8 1 00
04 1 9a000011 3 3c
04 2 ab000021 3 3c
04 1 9a000012 3 3c
04 2 ab000022 3 3c
04 1 9a000013 3 3c
04 2 ab000023 3 3c
05 0 8e5d7a21 3 28
05 4 a13c6b9f 3 28
05 1 e7f4208c 3 28
06 0 51234567 0 30
06 0 5a5a5a5a 0 30
06 0 5fedcba9 0 30
06 0 50f0f0f0 0 30
